// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= conv5_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
design/conv5_pkg.sv
design/conv5_line_buffer.sv
design/conv5_window_pad.sv
design/conv5_mac.sv
design/conv5_regs.sv
design/conv5_ctrl.sv
design/conv5_top.sv
test/conv5_props.sv
test/conv5_tb.sv

// File: design/conv5_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_start,
  input  conv5_pkg::pix_beat_t  i_pix,
  input  logic                  i_last_res,
  output logic                  o_shift,
  output logic                  o_out_en,
  output logic                  o_clear,
  output logic                  o_busy,
  output logic                  o_done,
  output conv5_pkg::pix_t       o_pix
);

  localparam int CNT_W = conv5_pkg::CNT_W;

  conv5_pkg::ctrl_state_e state_q;
  conv5_pkg::ctrl_state_e state_d;
  logic [CNT_W-1:0] cnt_q;
  logic start_ok;

  assign start_ok = i_start &
                    (state_q == conv5_pkg::ST_IDLE || state_q == conv5_pkg::ST_DONE);

  always_comb begin
    state_d = state_q;
    o_shift = 1'b0;
    case (state_q)
      conv5_pkg::ST_IDLE,
      conv5_pkg::ST_DONE: begin
        if (i_start) begin
          state_d = conv5_pkg::ST_RUN;
        end
      end
      conv5_pkg::ST_RUN: begin
        o_shift = i_pix.valid;
        if (i_pix.valid && cnt_q == CNT_W'(conv5_pkg::FRAME_PIX - 1)) begin
          state_d = conv5_pkg::ST_FLUSH;
        end
      end
      conv5_pkg::ST_FLUSH: begin
        // zero shifts, then wait for the final result.
        o_shift = (cnt_q < CNT_W'(conv5_pkg::FRAME_SHIFTS));
        if (i_last_res) begin
          state_d = conv5_pkg::ST_DONE;
        end
      end
      default: state_d = conv5_pkg::ST_IDLE;
    endcase
  end

  // counts every shift of the frame, pixels and flush alike.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= conv5_pkg::ST_IDLE;
      cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        cnt_q <= '0;
      end else if (o_shift) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign o_out_en = o_shift & (cnt_q >= CNT_W'(conv5_pkg::PRIME_CNT));
  assign o_clear = start_ok;
  assign o_busy = (state_q == conv5_pkg::ST_RUN) | (state_q == conv5_pkg::ST_FLUSH);
  assign o_done = (state_q == conv5_pkg::ST_DONE);
  assign o_pix = (state_q == conv5_pkg::ST_FLUSH) ? '0 : i_pix.data;

endmodule

`default_nettype wire

// File: design/conv5_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_line_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_shift,
  input  conv5_pkg::pix_t       i_pix,
  output conv5_pkg::col_taps_t  o_col
);

  localparam int NLINES = conv5_pkg::KSIZE - 1;
  localparam int LEN = conv5_pkg::IMG_COLS;

  conv5_pkg::pix_t line_q [NLINES][LEN];
  conv5_pkg::col_taps_t col_q;

  // each line delays by one full row.
  always_ff @(posedge clk) begin
    if (i_shift) begin
      line_q[NLINES-1][0] <= i_pix;
      for (int r = 0; r < NLINES - 1; r++) begin
        line_q[r][0] <= line_q[r+1][LEN-1];
      end
      for (int r = 0; r < NLINES; r++) begin
        for (int c = 1; c < LEN; c++) begin
          line_q[r][c] <= line_q[r][c-1];
        end
      end
    end
  end

  // newest pixel lands in row 4.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (i_shift) begin
      col_q[NLINES] <= i_pix;
      for (int r = 0; r < NLINES; r++) begin
        col_q[r] <= line_q[r][LEN-1];
      end
    end
  end

  assign o_col = col_q;

endmodule

`default_nettype wire

// File: design/conv5_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_mac (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv5_pkg::window_t    i_win,
  input  logic                  i_win_valid,
  input  logic                  i_last,
  input  conv5_pkg::weights_t   i_wgt,
  output conv5_pkg::res_beat_t  o_res
);

  localparam int KTAPS = conv5_pkg::KTAPS;
  localparam int PROD_W = conv5_pkg::PROD_W;
  localparam int ACC_W = conv5_pkg::ACC_W;

  logic signed [PROD_W-1:0] prod_q [KTAPS];
  logic signed [ACC_W-1:0] sum;
  logic signed [ACC_W-1:0] acc_q;
  logic v1_q;
  logic last1_q;
  logic v2_q;
  logic last2_q;

  // stage one.
  always_ff @(posedge clk) begin
    for (int k = 0; k < KTAPS; k++) begin
      prod_q[k] <= $signed({1'b0, i_win[k]}) * $signed(i_wgt[k]);
    end
  end

  // products are sign extended into the accumulator width.
  always_comb begin
    sum = '0;
    for (int k = 0; k < KTAPS; k++) begin
      sum = sum + prod_q[k];
    end
  end

  // stage two.
  always_ff @(posedge clk) begin
    acc_q <= sum;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      last1_q <= 1'b0;
      v2_q <= 1'b0;
      last2_q <= 1'b0;
    end else begin
      v1_q <= i_win_valid;
      last1_q <= i_win_valid & i_last;
      v2_q <= v1_q;
      last2_q <= v1_q & last1_q;
    end
  end

  assign o_res = conv5_pkg::res_beat_t'{valid: v2_q, last: last2_q, data: acc_q};

endmodule

`default_nettype wire

// File: design/conv5_pkg.sv
`default_nettype none

package conv5_pkg;

  // frame geometry.
  localparam int IMG_ROWS = 7;
  localparam int IMG_COLS = 7;
  localparam int KSIZE = 5;
  localparam int KHALF = 2;
  localparam int KTAPS = KSIZE * KSIZE;

  localparam int PIX_W = 8;
  localparam int WGT_W = 8;
  localparam int ACC_W = 24;
  // unsigned pixel widened by a sign bit, times a signed weight.
  localparam int PROD_W = PIX_W + 1 + WGT_W;

  // shifts needed before the window centres on pixel (0,0).
  localparam int PRIME_CNT = KHALF * IMG_COLS + KHALF;
  localparam int FRAME_PIX = IMG_ROWS * IMG_COLS;
  localparam int FRAME_SHIFTS = FRAME_PIX + PRIME_CNT;
  localparam int CNT_W = $clog2(FRAME_SHIFTS + 1);
  localparam int ROW_W = $clog2(IMG_ROWS);
  localparam int COL_W = $clog2(IMG_COLS);

  // register map.
  localparam int AXI_AW = 8;
  localparam int AXI_DW = 32;
  localparam int WIDX_W = $clog2(KTAPS);
  localparam logic [AXI_AW-1:0] REG_CTRL = 8'h00;
  localparam logic [AXI_AW-1:0] REG_STATUS = 8'h04;
  localparam logic [AXI_AW-1:0] REG_WGT_BASE = 8'h40;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [PIX_W-1:0] pix_t;

  // index 0 is the oldest row.
  typedef pix_t [KSIZE-1:0] col_taps_t;

  // row-major, tap 12 is the centre.
  typedef pix_t [KTAPS-1:0] window_t;

  typedef logic [KTAPS-1:0][WGT_W-1:0] weights_t;

  typedef struct packed {
    logic valid;
    pix_t data;
  } pix_beat_t;

  typedef struct packed {
    logic valid;
    logic last;
    logic signed [ACC_W-1:0] data;
  } res_beat_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FLUSH,
    ST_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/conv5_regs.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [conv5_pkg::AXI_AW-1:0]  i_awaddr,
  input  logic                          i_awvalid,
  output logic                          o_awready,
  input  logic [conv5_pkg::AXI_DW-1:0]  i_wdata,
  input  logic [3:0]                    i_wstrb,
  input  logic                          i_wvalid,
  output logic                          o_wready,
  output logic [1:0]                    o_bresp,
  output logic                          o_bvalid,
  input  logic                          i_bready,
  input  logic [conv5_pkg::AXI_AW-1:0]  i_araddr,
  input  logic                          i_arvalid,
  output logic                          o_arready,
  output logic [conv5_pkg::AXI_DW-1:0]  o_rdata,
  output logic [1:0]                    o_rresp,
  output logic                          o_rvalid,
  input  logic                          i_rready,
  input  logic                          i_busy,
  input  logic                          i_done,
  output conv5_pkg::weights_t           o_wgt,
  output logic                          o_start
);

  localparam int AW = conv5_pkg::AXI_AW;
  localparam int DW = conv5_pkg::AXI_DW;
  localparam int WGT_W = conv5_pkg::WGT_W;
  localparam int WIDX_W = conv5_pkg::WIDX_W;

  logic aw_rdy_q;
  logic bvalid_q;
  logic [1:0] bresp_q;
  logic ar_rdy_q;
  logic rvalid_q;
  logic [DW-1:0] rdata_q;
  logic [DW-1:0] rd_data;
  logic start_q;
  logic wr_fire;
  logic rd_fire;
  conv5_pkg::weights_t wgt_q;

  function automatic logic is_wgt(input logic [AW-1:0] addr);
    return addr >= conv5_pkg::REG_WGT_BASE &&
           addr < conv5_pkg::REG_WGT_BASE + 4 * conv5_pkg::KTAPS &&
           addr[1:0] == 2'b00;
  endfunction

  function automatic logic [WIDX_W-1:0] wgt_idx(input logic [AW-1:0] addr);
    logic [AW-1:0] off;
    off = addr - conv5_pkg::REG_WGT_BASE;
    return off[WIDX_W+1:2];
  endfunction

  assign wr_fire = aw_rdy_q & i_awvalid & i_wvalid;
  assign rd_fire = ar_rdy_q & i_arvalid;

  // write channel. weights are locked while a frame runs.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_rdy_q <= 1'b0;
      bvalid_q <= 1'b0;
      bresp_q <= conv5_pkg::RESP_OKAY;
      start_q <= 1'b0;
      wgt_q <= '0;
    end else begin
      start_q <= 1'b0;
      aw_rdy_q <= i_awvalid & i_wvalid & ~aw_rdy_q & ~bvalid_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q <= conv5_pkg::RESP_OKAY;
        if (is_wgt(i_awaddr)) begin
          if (i_busy) begin
            bresp_q <= conv5_pkg::RESP_SLVERR;
          end else if (i_wstrb[0]) begin
            wgt_q[wgt_idx(i_awaddr)] <= i_wdata[WGT_W-1:0];
          end
        end else if (i_awaddr == conv5_pkg::REG_CTRL && i_wstrb[0]) begin
          start_q <= i_wdata[0];
        end
      end else if (bvalid_q && i_bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // read mux, weights come back sign extended.
  always_comb begin
    logic [WGT_W-1:0] w;
    w = wgt_q[wgt_idx(i_araddr)];
    rd_data = '0;
    if (i_araddr == conv5_pkg::REG_STATUS) begin
      rd_data[1:0] = {i_done, i_busy};
    end else if (is_wgt(i_araddr)) begin
      rd_data = {{(DW - WGT_W){w[WGT_W-1]}}, w};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_rdy_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      ar_rdy_q <= i_arvalid & ~ar_rdy_q & ~rvalid_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
    end
  end

  assign o_awready = aw_rdy_q;
  assign o_wready = aw_rdy_q;
  assign o_bvalid = bvalid_q;
  assign o_bresp = bresp_q;
  assign o_arready = ar_rdy_q;
  assign o_rvalid = rvalid_q;
  assign o_rdata = rdata_q;
  assign o_rresp = conv5_pkg::RESP_OKAY;
  assign o_wgt = wgt_q;
  assign o_start = start_q;

endmodule

`default_nettype wire

// File: design/conv5_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [conv5_pkg::AXI_AW-1:0]  i_awaddr,
  input  logic                          i_awvalid,
  output logic                          o_awready,
  input  logic [conv5_pkg::AXI_DW-1:0]  i_wdata,
  input  logic [3:0]                    i_wstrb,
  input  logic                          i_wvalid,
  output logic                          o_wready,
  output logic [1:0]                    o_bresp,
  output logic                          o_bvalid,
  input  logic                          i_bready,
  input  logic [conv5_pkg::AXI_AW-1:0]  i_araddr,
  input  logic                          i_arvalid,
  output logic                          o_arready,
  output logic [conv5_pkg::AXI_DW-1:0]  o_rdata,
  output logic [1:0]                    o_rresp,
  output logic                          o_rvalid,
  input  logic                          i_rready,
  input  conv5_pkg::pix_beat_t          i_pix,
  output conv5_pkg::res_beat_t          o_res
);

  conv5_pkg::weights_t wgt;
  conv5_pkg::pix_t pix;
  conv5_pkg::col_taps_t col;
  conv5_pkg::window_t win;
  logic start;
  logic busy;
  logic done;
  logic shift;
  logic out_en;
  logic clear;
  logic win_valid;
  logic win_last;

  conv5_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awaddr  (i_awaddr),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_araddr  (i_araddr),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .i_busy    (busy),
    .i_done    (done),
    .o_wgt     (wgt),
    .o_start   (start)
  );

  // the mac only raises last together with valid.
  conv5_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (start),
    .i_pix      (i_pix),
    .i_last_res (o_res.last),
    .o_shift    (shift),
    .o_out_en   (out_en),
    .o_clear    (clear),
    .o_busy     (busy),
    .o_done     (done),
    .o_pix      (pix)
  );

  conv5_line_buffer u_line_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_shift (shift),
    .i_pix   (pix),
    .o_col   (col)
  );

  conv5_window_pad u_window_pad (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_shift     (shift),
    .i_out_en    (out_en),
    .i_clear     (clear),
    .i_col       (col),
    .o_win       (win),
    .o_win_valid (win_valid),
    .o_last      (win_last)
  );

  conv5_mac u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win       (win),
    .i_win_valid (win_valid),
    .i_last      (win_last),
    .i_wgt       (wgt),
    .o_res       (o_res)
  );

endmodule

`default_nettype wire

// File: design/conv5_window_pad.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_window_pad (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_shift,
  input  logic                  i_out_en,
  input  logic                  i_clear,
  input  conv5_pkg::col_taps_t  i_col,
  output conv5_pkg::window_t    o_win,
  output logic                  o_win_valid,
  output logic                  o_last
);

  localparam int ROW_W = conv5_pkg::ROW_W;
  localparam int COL_W = conv5_pkg::COL_W;
  localparam int KSIZE = conv5_pkg::KSIZE;

  logic shift_q;
  logic out_en_q;
  logic [ROW_W-1:0] row_q;
  logic [COL_W-1:0] col_q;
  logic row_end;
  logic col_end;
  conv5_pkg::window_t win_q;
  conv5_pkg::window_t nxt_win;
  conv5_pkg::window_t masked;

  // the column is valid one cycle after its shift.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q <= 1'b0;
      out_en_q <= 1'b0;
    end else begin
      shift_q <= i_shift;
      out_en_q <= i_out_en;
    end
  end

  assign row_end = (row_q == ROW_W'(conv5_pkg::IMG_ROWS - 1));
  assign col_end = (col_q == COL_W'(conv5_pkg::IMG_COLS - 1));

  // output position, raster order.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_q <= '0;
      col_q <= '0;
    end else if (i_clear) begin
      row_q <= '0;
      col_q <= '0;
    end else if (out_en_q) begin
      if (col_end) begin
        col_q <= '0;
        row_q <= row_end ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // older taps move one place left, the new column enters at the right.
  always_comb begin
    nxt_win = conv5_pkg::window_t'(win_q >> conv5_pkg::PIX_W);
    for (int kr = 0; kr < KSIZE; kr++) begin
      nxt_win[kr*KSIZE + KSIZE - 1] = i_col[kr];
    end
  end

  // zero taps outside the frame.
  always_comb begin
    int rr;
    int cc;
    masked = nxt_win;
    for (int kr = 0; kr < KSIZE; kr++) begin
      for (int kc = 0; kc < KSIZE; kc++) begin
        rr = int'(row_q) + kr - conv5_pkg::KHALF;
        cc = int'(col_q) + kc - conv5_pkg::KHALF;
        if (rr < 0 || rr >= conv5_pkg::IMG_ROWS || cc < 0 || cc >= conv5_pkg::IMG_COLS) begin
          masked[kr*KSIZE + kc] = '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (shift_q) begin
      win_q <= nxt_win;
    end
    if (out_en_q) begin
      o_win <= masked;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_win_valid <= 1'b0;
      o_last <= 1'b0;
    end else begin
      o_win_valid <= out_en_q;
      o_last <= out_en_q & row_end & col_end;
    end
  end

endmodule

`default_nettype wire

// File: test/conv5_props.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  i_shift,
  input logic                  i_out_en,
  input logic                  i_busy,
  input logic                  i_done,
  input conv5_pkg::res_beat_t  i_res
);

  // an output slot always consumes a shift.
  out_en_with_shift: assert property (@(posedge clk) disable iff (!rst_n)
    i_out_en |-> i_shift)
    else $error("out_en raised without shift");

  // done one cycle after the final result.
  last_then_done: assert property (@(posedge clk) disable iff (!rst_n)
    (i_res.valid && i_res.last) |=> i_done)
    else $error("done did not follow the last result");

  busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_busy && i_done))
    else $error("busy and done high together");

endmodule

bind conv5_top conv5_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .i_shift  (shift),
  .i_out_en (out_en),
  .i_busy   (busy),
  .i_done   (done),
  .i_res    (o_res)
);

`default_nettype wire

// File: test/conv5_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv5_tb;

  localparam int ACC_W = conv5_pkg::ACC_W;
  localparam int KTAPS = conv5_pkg::KTAPS;
  localparam int FRAME_PIX = conv5_pkg::FRAME_PIX;
  localparam int LOCK_IDX = 7;
  // three frames at worst four cycles per pixel, plus register traffic.
  localparam int FRAME_CYC = FRAME_PIX * 4 + conv5_pkg::PRIME_CNT + 8;
  localparam int AXI_OPS = 120;
  localparam int TIMEOUT_CYC = 3 * FRAME_CYC + AXI_OPS * 6 + 200;

  logic clk;
  logic rst_n;
  logic [7:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [7:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  conv5_pkg::pix_beat_t pix;
  conv5_pkg::res_beat_t res;

  logic [31:0] lfsr_q;
  conv5_pkg::pix_t frame_px [FRAME_PIX];
  logic signed [7:0] wgt_a [KTAPS];
  logic signed [7:0] wgt_cur [KTAPS];
  logic signed [ACC_W-1:0] exp_mem [FRAME_PIX];
  int exp_total;
  int res_cnt;
  int res_errs;
  int last_errs;
  int reg_errs;
  int stray_errs;

  conv5_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .i_pix     (pix),
    .o_res     (res)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // zero padded 5x5 correlation of the stored frame.
  function automatic logic signed [ACC_W-1:0] ref_conv(input int r, input int c);
    int acc;
    int rr;
    int cc;
    acc = 0;
    for (int kr = 0; kr < conv5_pkg::KSIZE; kr++) begin
      for (int kc = 0; kc < conv5_pkg::KSIZE; kc++) begin
        rr = r + kr - conv5_pkg::KHALF;
        cc = c + kc - conv5_pkg::KHALF;
        if (rr >= 0 && rr < conv5_pkg::IMG_ROWS && cc >= 0 && cc < conv5_pkg::IMG_COLS) begin
          acc += int'(frame_px[rr * conv5_pkg::IMG_COLS + cc]) *
                 int'(wgt_cur[kr * conv5_pkg::KSIZE + kc]);
        end
      end
    end
    return acc[ACC_W-1:0];
  endfunction

  task automatic check_res(input logic signed [ACC_W-1:0] got,
                           input logic signed [ACC_W-1:0] exp, input int idx);
    if (got !== exp) begin
      res_errs++;
      $display("[FAIL] %0t result at row %0d col %0d: got %0d expected %0d", $time,
               idx / conv5_pkg::IMG_COLS, idx % conv5_pkg::IMG_COLS, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      last_errs++;
      $display("[FAIL] %0t last flag at result %0d: got %0b expected %0b", $time,
               idx, got, exp);
    end
  endtask

  task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      reg_errs++;
      $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp,
                            input string what);
    if (got !== exp) begin
      reg_errs++;
      $display("[FAIL] %0t %s response: got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    awaddr <= addr;
    wdata <= data;
    wstrb <= 4'hf;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do @(posedge clk); while (!awready);
    if (!wready) begin
      reg_errs++;
      $display("[FAIL] %0t wready low while awready high", $time);
    end
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b1;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    araddr <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    rready <= 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    check_resp(rresp, conv5_pkg::RESP_OKAY, "read");
    rready <= 1'b0;
  endtask

  task automatic load_weights();
    logic [1:0] resp;
    for (int k = 0; k < KTAPS; k++) begin
      write_reg(8'(conv5_pkg::REG_WGT_BASE + 4 * k), {24'h0, wgt_cur[k]}, resp);
      check_resp(resp, conv5_pkg::RESP_OKAY, "weight write");
    end
  endtask

  task automatic drive_frame(input bit gaps);
    logic [7:0] idle;
    for (int i = 0; i < FRAME_PIX; i++) begin
      if (gaps) begin
        idle = take_bits(2);
        repeat (idle) begin
          @(posedge clk);
          pix.valid <= 1'b0;
        end
      end
      @(posedge clk);
      pix <= conv5_pkg::pix_beat_t'{valid: 1'b1, data: frame_px[i]};
    end
    @(posedge clk);
    pix.valid <= 1'b0;
  endtask

  // start, stream one frame, wait for all of its results.
  task automatic run_frame(input bit gaps, input bit try_lock);
    logic [31:0] d;
    logic [1:0] resp;
    exp_total += FRAME_PIX;
    write_reg(conv5_pkg::REG_CTRL, 32'h1, resp);
    check_resp(resp, conv5_pkg::RESP_OKAY, "start");
    d = '0;
    while (!d[0]) begin
      read_reg(conv5_pkg::REG_STATUS, d);
    end
    fork
      drive_frame(gaps);
      if (try_lock) begin
        write_reg(8'(conv5_pkg::REG_WGT_BASE + 4 * LOCK_IDX), {24'h0, ~wgt_a[LOCK_IDX]}, resp);
        check_resp(resp, conv5_pkg::RESP_SLVERR, "weight write while busy");
      end
    join
    while (res_cnt < exp_total) begin
      @(posedge clk);
    end
    read_reg(conv5_pkg::REG_STATUS, d);
    check_rdata(d, 32'h2, "status after frame");
  endtask

  task automatic print_counts();
    $display("errors: result=%0d last=%0d register=%0d stray=%0d",
             res_errs, last_errs, reg_errs, stray_errs);
  endtask

  // results are sampled at the edge, before the DUT updates them.
  always @(posedge clk) begin
    if (rst_n && res.valid) begin
      if (res_cnt >= exp_total) begin
        stray_errs++;
        $display("%0t: a result arrived beyond the expected frame length", $time);
      end else begin
        check_res(res.data, exp_mem[res_cnt % FRAME_PIX], res_cnt % FRAME_PIX);
        check_last(res.last, (res_cnt % FRAME_PIX) == FRAME_PIX - 1, res_cnt);
      end
      res_cnt++;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles: results stopped arriving, %0d of %0d seen",
             cycles, res_cnt, exp_total);
    print_counts();
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    logic [31:0] d;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    pix = '0;
    lfsr_q = 32'hdb01;
    exp_total = 0;
    res_cnt = 0;
    res_errs = 0;
    last_errs = 0;
    reg_errs = 0;
    stray_errs = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    read_reg(conv5_pkg::REG_STATUS, d);
    check_rdata(d, 32'h0, "status after reset");
    read_reg(8'h20, d);
    check_rdata(d, 32'h0, "unmapped read");

    // readback with sign extension.
    for (int k = 0; k < KTAPS; k++) begin
      wgt_a[k] = take_bits(8);
    end
    wgt_cur = wgt_a;
    load_weights();
    for (int k = 0; k < KTAPS; k++) begin
      read_reg(8'(conv5_pkg::REG_WGT_BASE + 4 * k), d);
      check_rdata(d, {{24{wgt_a[k][7]}}, wgt_a[k]}, "weight readback");
    end

    // identity kernel passes pixels through.
    for (int k = 0; k < KTAPS; k++) begin
      wgt_cur[k] = (k == KTAPS / 2) ? 8'sd1 : 8'sd0;
    end
    load_weights();
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_px[i] = take_bits(8);
      exp_mem[i] = {{(ACC_W - conv5_pkg::PIX_W){1'b0}}, frame_px[i]};
    end
    run_frame(1'b0, 1'b0);

    wgt_cur = wgt_a;
    load_weights();
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_px[i] = take_bits(8);
    end
    for (int i = 0; i < FRAME_PIX; i++) begin
      exp_mem[i] = ref_conv(i / conv5_pkg::IMG_COLS, i % conv5_pkg::IMG_COLS);
    end
    run_frame(1'b0, 1'b0);

    // same frame with gaps, and a weight write that must be refused.
    run_frame(1'b1, 1'b1);
    read_reg(8'(conv5_pkg::REG_WGT_BASE + 4 * LOCK_IDX), d);
    check_rdata(d, {{24{wgt_a[LOCK_IDX][7]}}, wgt_a[LOCK_IDX]}, "locked weight readback");

    repeat (8) @(posedge clk);
    print_counts();
    if (res_errs + last_errs + reg_errs + stray_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
